//--- include/rv_exec_cfg.svh
`ifndef RV_EXEC_CFG_SVH
`define RV_EXEC_CFG_SVH

////////////////////////////////////////////////////////////////////////////
// RV32I base integer sizes
////////////////////////////////////////////////////////////////////////////

// data word width
`define RV_XLEN 32

// architectural registers including x0
`define RV_REG_COUNT 32

// register address width
`define RV_REG_AW 5

`endif

//--- src/rv_exec_pkg.sv
`default_nettype none

`include "rv_exec_cfg.svh"

package rv_exec_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // alu operations
    ////////////////////////////////////////////////////////////////////////////

    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_AND  = 4'd2,
        ALU_OR   = 4'd3,
        ALU_XOR  = 4'd4,
        ALU_SLT  = 4'd5,  // signed compare
        ALU_SLTU = 4'd6,  // unsigned compare
        ALU_SLL  = 4'd7,
        ALU_SRL  = 4'd8,
        ALU_SRA  = 4'd9
    } alu_op_e;

    ////////////////////////////////////////////////////////////////////////////
    // instruction formats
    ////////////////////////////////////////////////////////////////////////////

    typedef struct packed {
        logic [6:0]            funct7;
        logic [`RV_REG_AW-1:0] rs2;
        logic [`RV_REG_AW-1:0] rs1;
        logic [2:0]            funct3;
        logic [`RV_REG_AW-1:0] rd;
        logic [6:0]            opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0]           imm12;  // sign bit is imm12[11]
        logic [`RV_REG_AW-1:0] rs1;
        logic [2:0]            funct3;
        logic [`RV_REG_AW-1:0] rd;
        logic [6:0]            opcode;
    } i_fmt_t;

    // one word seen through two views
    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
    } instr_u;

    // major opcodes
    parameter logic [6:0] OPC_OP     = 7'b0110011;
    parameter logic [6:0] OPC_OP_IMM = 7'b0010011;

    // funct3 encodings
    parameter logic [2:0] F3_ADD_SUB = 3'b000;
    parameter logic [2:0] F3_SLL     = 3'b001;
    parameter logic [2:0] F3_SLT     = 3'b010;
    parameter logic [2:0] F3_SLTU    = 3'b011;
    parameter logic [2:0] F3_XOR     = 3'b100;
    parameter logic [2:0] F3_SRL_SRA = 3'b101;
    parameter logic [2:0] F3_OR      = 3'b110;
    parameter logic [2:0] F3_AND     = 3'b111;

    parameter logic [6:0] F7_BASE = 7'b0000000;
    parameter logic [6:0] F7_ALT  = 7'b0100000;  // sub / sra

endpackage

`default_nettype wire

//--- src/rv_decoder.sv
`default_nettype none

`include "rv_exec_cfg.svh"

module rv_decoder (
    input  wire logic                   clk_i,
    input  wire logic                   rst_n_i,
    input  wire logic                   instr_valid_i,
    input  wire rv_exec_pkg::instr_u    instr_i,
    output logic [`RV_REG_AW-1:0]       rs1_addr_o,
    output logic [`RV_REG_AW-1:0]       rs2_addr_o,
    output logic [`RV_REG_AW-1:0]       rd_addr_o,
    output rv_exec_pkg::alu_op_e        alu_op_o,
    output logic [`RV_XLEN-1:0]         imm_o,
    output logic                        use_imm_o,
    output logic                        issue_o,
    output logic                        illegal_o
);

    logic legal;

    // register fields sit at the same bits in both formats
    assign rs1_addr_o = instr_i.r.rs1;
    assign rs2_addr_o = instr_i.r.rs2;
    assign rd_addr_o  = instr_i.r.rd;

    assign imm_o = {{(`RV_XLEN-12){instr_i.i.imm12[11]}}, instr_i.i.imm12};

    ////////////////////////////////////////////////////////////////////////////
    // opcode and funct decode
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        alu_op_o  = rv_exec_pkg::ALU_ADD;
        use_imm_o = 1'b0;
        legal     = 1'b0;
        case (instr_i.r.opcode)
            rv_exec_pkg::OPC_OP: begin
                // funct7 must be base, except add/sub and srl/sra
                legal = (instr_i.r.funct7 == rv_exec_pkg::F7_BASE);
                case (instr_i.r.funct3)
                    rv_exec_pkg::F3_ADD_SUB: begin
                        legal    = legal || (instr_i.r.funct7 == rv_exec_pkg::F7_ALT);
                        alu_op_o = (instr_i.r.funct7 == rv_exec_pkg::F7_ALT) ?
                                   rv_exec_pkg::ALU_SUB : rv_exec_pkg::ALU_ADD;
                    end
                    rv_exec_pkg::F3_SRL_SRA: begin
                        legal    = legal || (instr_i.r.funct7 == rv_exec_pkg::F7_ALT);
                        alu_op_o = (instr_i.r.funct7 == rv_exec_pkg::F7_ALT) ?
                                   rv_exec_pkg::ALU_SRA : rv_exec_pkg::ALU_SRL;
                    end
                    rv_exec_pkg::F3_SLL:  alu_op_o = rv_exec_pkg::ALU_SLL;
                    rv_exec_pkg::F3_SLT:  alu_op_o = rv_exec_pkg::ALU_SLT;
                    rv_exec_pkg::F3_SLTU: alu_op_o = rv_exec_pkg::ALU_SLTU;
                    rv_exec_pkg::F3_XOR:  alu_op_o = rv_exec_pkg::ALU_XOR;
                    rv_exec_pkg::F3_OR:   alu_op_o = rv_exec_pkg::ALU_OR;
                    default:              alu_op_o = rv_exec_pkg::ALU_AND;
                endcase
            end
            rv_exec_pkg::OPC_OP_IMM: begin
                use_imm_o = 1'b1;
                legal     = 1'b1;
                case (instr_i.i.funct3)
                    rv_exec_pkg::F3_ADD_SUB: alu_op_o = rv_exec_pkg::ALU_ADD;  // addi
                    rv_exec_pkg::F3_SLT:     alu_op_o = rv_exec_pkg::ALU_SLT;
                    rv_exec_pkg::F3_SLTU:    alu_op_o = rv_exec_pkg::ALU_SLTU;
                    rv_exec_pkg::F3_XOR:     alu_op_o = rv_exec_pkg::ALU_XOR;
                    rv_exec_pkg::F3_OR:      alu_op_o = rv_exec_pkg::ALU_OR;
                    rv_exec_pkg::F3_AND:     alu_op_o = rv_exec_pkg::ALU_AND;
                    rv_exec_pkg::F3_SLL: begin
                        // upper imm bits act as funct7 for shifts
                        legal    = (instr_i.r.funct7 == rv_exec_pkg::F7_BASE);
                        alu_op_o = rv_exec_pkg::ALU_SLL;
                    end
                    default: begin  // srli / srai
                        legal    = (instr_i.r.funct7 == rv_exec_pkg::F7_BASE) ||
                                   (instr_i.r.funct7 == rv_exec_pkg::F7_ALT);
                        alu_op_o = (instr_i.r.funct7 == rv_exec_pkg::F7_ALT) ?
                                   rv_exec_pkg::ALU_SRA : rv_exec_pkg::ALU_SRL;
                    end
                endcase
            end
            default: legal = 1'b0;  // unsupported opcode
        endcase
    end

    assign issue_o = instr_valid_i & legal;

    // one-cycle pulse in the same cycle as result_valid_o would be
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            illegal_o <= 1'b0;
        end else begin
            illegal_o <= instr_valid_i & ~legal;
        end
    end

endmodule

`default_nettype wire

//--- src/rv_regfile.sv
`default_nettype none

`include "rv_exec_cfg.svh"

module rv_regfile (
    input  wire logic                 clk_i,
    input  wire logic                 rst_n_i,
    input  wire logic [`RV_REG_AW-1:0] rs1_addr_i,
    input  wire logic [`RV_REG_AW-1:0] rs2_addr_i,
    input  wire logic [`RV_REG_AW-1:0] rd_addr_i,
    input  wire logic                 wr_en_i,
    input  wire logic [`RV_XLEN-1:0]  wr_data_i,
    output logic [`RV_XLEN-1:0]       rs1_data_o,
    output logic [`RV_XLEN-1:0]       rs2_data_o
);

    logic [`RV_XLEN-1:0] regs [`RV_REG_COUNT];

    ////////////////////////////////////////////////////////////////////////////
    // write port
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < `RV_REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en_i && (rd_addr_i != '0)) begin  // x0 stays zero
            regs[rd_addr_i] <= wr_data_i;
        end
    end

    // read ports without bypass
    // a write lands at the edge, so the next cycle already reads it
    assign rs1_data_o = regs[rs1_addr_i];
    assign rs2_data_o = regs[rs2_addr_i];

endmodule

`default_nettype wire

//--- src/rv_alu.sv
`default_nettype none

`include "rv_exec_cfg.svh"

module rv_alu (
    input  wire logic                  clk_i,
    input  wire logic                  rst_n_i,
    input  wire logic                  issue_i,
    input  wire rv_exec_pkg::alu_op_e  alu_op_i,
    input  wire logic [`RV_XLEN-1:0]   rs1_data_i,
    input  wire logic [`RV_XLEN-1:0]   rs2_data_i,
    input  wire logic [`RV_XLEN-1:0]   imm_i,
    input  wire logic                  use_imm_i,
    output logic [`RV_XLEN-1:0]        wb_data_o,
    output logic [`RV_XLEN-1:0]        result_o,
    output logic                       result_valid_o,
    output logic                       zero_o,
    output logic                       sign_o,
    output logic                       overflow_o
);

    logic [`RV_XLEN-1:0] op_a;
    logic [`RV_XLEN-1:0] op_b;
    logic [4:0]          shamt;   // rv32i shifts use low 5 bits only
    logic [`RV_XLEN-1:0] alu_res;
    logic                ovf;

    assign op_a  = rs1_data_i;
    assign op_b  = use_imm_i ? imm_i : rs2_data_i;
    assign shamt = op_b[4:0];

    ////////////////////////////////////////////////////////////////////////////
    // execute
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        case (alu_op_i)
            rv_exec_pkg::ALU_ADD:  alu_res = op_a + op_b;
            rv_exec_pkg::ALU_SUB:  alu_res = op_a - op_b;
            rv_exec_pkg::ALU_AND:  alu_res = op_a & op_b;
            rv_exec_pkg::ALU_OR:   alu_res = op_a | op_b;
            rv_exec_pkg::ALU_XOR:  alu_res = op_a ^ op_b;
            rv_exec_pkg::ALU_SLT:  alu_res = {31'd0, $signed(op_a) < $signed(op_b)};
            rv_exec_pkg::ALU_SLTU: alu_res = {31'd0, op_a < op_b};
            rv_exec_pkg::ALU_SLL:  alu_res = op_a << shamt;
            rv_exec_pkg::ALU_SRL:  alu_res = op_a >> shamt;
            rv_exec_pkg::ALU_SRA:  alu_res = $signed(op_a) >>> shamt;
            default:               alu_res = op_a;  // pass a through
        endcase
    end

    // signed overflow for add and sub only
    always_comb begin
        case (alu_op_i)
            rv_exec_pkg::ALU_ADD:
                ovf = (~op_a[31] & ~op_b[31] &  alu_res[31]) |
                      ( op_a[31] &  op_b[31] & ~alu_res[31]);
            rv_exec_pkg::ALU_SUB:
                ovf = (~op_a[31] &  op_b[31] &  alu_res[31]) |
                      ( op_a[31] & ~op_b[31] & ~alu_res[31]);
            default:
                ovf = 1'b0;
        endcase
    end

    assign wb_data_o = alu_res;  // straight to regfile write port

    ////////////////////////////////////////////////////////////////////////////
    // result registers
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            result_o       <= '0;
            result_valid_o <= 1'b0;
            zero_o         <= 1'b0;
            sign_o         <= 1'b0;
            overflow_o     <= 1'b0;
        end else begin
            result_valid_o <= issue_i;  // single-cycle pulse
            if (issue_i) begin
                result_o   <= alu_res;
                zero_o     <= ~(|alu_res);
                sign_o     <= alu_res[`RV_XLEN-1];
                overflow_o <= ovf;
            end
        end
    end

endmodule

`default_nettype wire

//--- src/rv_exec_top.sv
`default_nettype none

`include "rv_exec_cfg.svh"

module rv_exec_top (
    input  wire logic                clk_i,
    input  wire logic                rst_n_i,
    input  wire logic                instr_valid_i,
    input  wire logic [`RV_XLEN-1:0] instr_i,
    output logic [`RV_XLEN-1:0]      result_o,
    output logic                     result_valid_o,
    output logic                     zero_o,
    output logic                     sign_o,
    output logic                     overflow_o,
    output logic                     illegal_o
);

    logic [`RV_REG_AW-1:0] rs1_addr;
    logic [`RV_REG_AW-1:0] rs2_addr;
    logic [`RV_REG_AW-1:0] rd_addr;
    rv_exec_pkg::alu_op_e  alu_op;
    logic [`RV_XLEN-1:0]   imm;
    logic                  use_imm;
    logic                  issue;     // also the regfile write enable
    logic [`RV_XLEN-1:0]   rs1_data;
    logic [`RV_XLEN-1:0]   rs2_data;
    logic [`RV_XLEN-1:0]   wb_data;

    rv_decoder u_decoder (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .instr_valid_i (instr_valid_i),
        .instr_i       (instr_i),
        .rs1_addr_o    (rs1_addr),
        .rs2_addr_o    (rs2_addr),
        .rd_addr_o     (rd_addr),
        .alu_op_o      (alu_op),
        .imm_o         (imm),
        .use_imm_o     (use_imm),
        .issue_o       (issue),
        .illegal_o     (illegal_o)
    );

    rv_regfile u_regfile (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .rs1_addr_i (rs1_addr),
        .rs2_addr_i (rs2_addr),
        .rd_addr_i  (rd_addr),
        .wr_en_i    (issue),
        .wr_data_i  (wb_data),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data)
    );

    rv_alu u_alu (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .issue_i        (issue),
        .alu_op_i       (alu_op),
        .rs1_data_i     (rs1_data),
        .rs2_data_i     (rs2_data),
        .imm_i          (imm),
        .use_imm_i      (use_imm),
        .wb_data_o      (wb_data),
        .result_o       (result_o),
        .result_valid_o (result_valid_o),
        .zero_o         (zero_o),
        .sign_o         (sign_o),
        .overflow_o     (overflow_o)
    );

endmodule

`default_nettype wire

//--- dv/rv_exec_asserts.sv
`default_nettype none

`include "rv_exec_cfg.svh"

module rv_exec_asserts (
    input wire logic                clk_i,
    input wire logic                rst_n_i,
    input wire logic                instr_valid_i,
    input wire logic [`RV_XLEN-1:0] result_i,
    input wire logic                result_valid_i,
    input wire logic                zero_i,
    input wire logic                sign_i,
    input wire logic                overflow_i,
    input wire logic                illegal_i
);

    // a word is either executed or rejected
    a_valid_or_illegal: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        !(result_valid_i && illegal_i))
        else $error("result_valid_o and illegal_o high together");

    a_valid_latency: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        result_valid_i |-> $past(instr_valid_i))
        else $error("result_valid_o without an instruction one cycle before");

    // checked from the second reset cycle on
    a_reset_outputs: assert property (@(posedge clk_i)
        (!rst_n_i && $past(!rst_n_i)) |->
        (result_i == '0 && !result_valid_i && !zero_i && !sign_i && !overflow_i && !illegal_i))
        else $error("outputs not cleared during reset");

    a_zero_flag: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        result_valid_i |-> (zero_i == (result_i == '0)))
        else $error("zero_o does not match result_o");

endmodule

bind rv_exec_top rv_exec_asserts u_asserts (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .instr_valid_i  (instr_valid_i),
    .result_i       (result_o),
    .result_valid_i (result_valid_o),
    .zero_i         (zero_o),
    .sign_i         (sign_o),
    .overflow_i     (overflow_o),
    .illegal_i      (illegal_o)
);

`default_nettype wire

//--- dv/rv_exec_tb.sv
`default_nettype none

`include "rv_exec_cfg.svh"

module rv_exec_tb;

    localparam int NUM_TESTS = 5;

    logic                clk_i;
    logic                rst_n_i;
    logic                instr_valid_i;
    logic [`RV_XLEN-1:0] instr_i;
    logic [`RV_XLEN-1:0] result_o;
    logic                result_valid_o;
    logic                zero_o;
    logic                sign_o;
    logic                overflow_o;
    logic                illegal_o;

    logic [`RV_XLEN-1:0] model [`RV_REG_COUNT];  // architectural register state
    logic [31:0]         lfsr;
    int                  errors;
    int                  checks;

    rv_exec_top u_dut (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .instr_valid_i  (instr_valid_i),
        .instr_i        (instr_i),
        .result_o       (result_o),
        .result_valid_o (result_valid_o),
        .zero_o         (zero_o),
        .sign_o         (sign_o),
        .overflow_o     (overflow_o),
        .illegal_o      (illegal_o)
    );

    always #5 clk_i = ~clk_i;

    // watchdog allows 200 cycles per test
    initial begin
        #(NUM_TESTS * 200 * 10);
        $display("Timeout: the tests did not finish within %0d time units", NUM_TESTS * 2000);
        $display("Some tests failed");
        $finish;
    end

    ////////////////////////////////////////////////////////////////////////////
    // stimulus helpers
    ////////////////////////////////////////////////////////////////////////////

    // taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic rand_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int k = 0; k < n; k++) begin
            lfsr = lfsr_next(lfsr);
            v    = {v[30:0], lfsr[0]};
        end
    endtask

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, rv_exec_pkg::OPC_OP};
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd);
        return {imm, rs1, f3, rd, rv_exec_pkg::OPC_OP_IMM};
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // reference model
    ////////////////////////////////////////////////////////////////////////////

    task automatic predict(input logic [31:0] w, output logic legal,
                           output logic [31:0] res, output logic ovf);
        logic [31:0] a;
        logic [31:0] b;
        logic [2:0]  f3;
        logic        is_imm;
        logic        base;
        logic        alt;
        f3     = w[14:12];
        is_imm = (w[6:0] == rv_exec_pkg::OPC_OP_IMM);
        base   = (w[31:25] == rv_exec_pkg::F7_BASE);
        alt    = (w[31:25] == rv_exec_pkg::F7_ALT);
        a      = model[w[19:15]];
        b      = is_imm ? {{20{w[31]}}, w[31:20]} : model[w[24:20]];
        legal  = 1'b0;
        if (w[6:0] == rv_exec_pkg::OPC_OP) begin
            legal = base || (alt && (f3 == rv_exec_pkg::F3_ADD_SUB ||
                                     f3 == rv_exec_pkg::F3_SRL_SRA));
        end else if (is_imm) begin  // funct7 field only counts for shifts
            legal = (f3 != rv_exec_pkg::F3_SLL && f3 != rv_exec_pkg::F3_SRL_SRA) ||
                    base || (alt && f3 == rv_exec_pkg::F3_SRL_SRA);
        end
        ovf = 1'b0;
        case (f3)
            rv_exec_pkg::F3_ADD_SUB: begin
                if (alt && !is_imm) begin
                    res = a - b;
                    ovf = (a[31] != b[31]) && (res[31] != a[31]);
                end else begin
                    res = a + b;
                    ovf = (a[31] == b[31]) && (res[31] != a[31]);
                end
            end
            rv_exec_pkg::F3_SLL:  res = a << b[4:0];
            rv_exec_pkg::F3_SLT:  res = {31'd0, $signed(a) < $signed(b)};
            rv_exec_pkg::F3_SLTU: res = {31'd0, a < b};
            rv_exec_pkg::F3_XOR:  res = a ^ b;
            rv_exec_pkg::F3_OR:   res = a | b;
            rv_exec_pkg::F3_AND:  res = a & b;
            default: begin
                if (alt) res = $signed(a) >>> b[4:0];
                else     res = a >> b[4:0];
            end
        endcase
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // drive and check
    ////////////////////////////////////////////////////////////////////////////

    // called 1 unit after a rising edge, returns at the same phase
    task automatic run_instr(input logic [31:0] w);
        logic        legal;
        logic [31:0] res;
        logic        ovf;
        predict(w, legal, res, ovf);
        instr_valid_i = 1'b1;
        instr_i       = w;
        @(posedge clk_i);
        #1;
        instr_valid_i = 1'b0;
        checks++;
        if (!legal) begin
            if (!illegal_o || result_valid_o) begin
                $display("Mismatch at %0t: word %h should be illegal, got illegal %b valid %b",
                         $time, w, illegal_o, result_valid_o);
                errors++;
            end
        end else if (!result_valid_o || illegal_o || result_o !== res ||
                     zero_o !== (res == '0) || sign_o !== res[31] || overflow_o !== ovf) begin
            $display("Mismatch at %0t: word %h got %h z%b s%b v%b, expected %h z%b s%b v%b",
                     $time, w, result_o, zero_o, sign_o, overflow_o,
                     res, (res == '0), res[31], ovf);
            errors++;
        end
        if (legal && w[11:7] != 5'd0) model[w[11:7]] = res;
    endtask

    // both pulses must be gone one cycle later
    task automatic check_idle();
        @(posedge clk_i);
        #1;
        checks++;
        if (result_valid_o || illegal_o) begin
            $display("Mismatch at %0t: pulse held too long, valid %b illegal %b",
                     $time, result_valid_o, illegal_o);
            errors++;
        end
    endtask

    task automatic check_flags(input logic exp_ovf, input logic exp_sign);
        checks++;
        if (overflow_o !== exp_ovf || sign_o !== exp_sign) begin
            $display("Mismatch at %0t: overflow %b sign %b, expected %b %b",
                     $time, overflow_o, sign_o, exp_ovf, exp_sign);
            errors++;
        end
    endtask

    // add x0, xn, x0 shows xn without writing anything
    task automatic read_reg(input logic [4:0] n);
        run_instr(enc_r(rv_exec_pkg::F7_BASE, 5'd0, n, rv_exec_pkg::F3_ADD_SUB, 5'd0));
    endtask

    task automatic report_test(input string name, input int err_before);
        $display("%s finished with %0d errors", name, errors - err_before);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // tests
    ////////////////////////////////////////////////////////////////////////////

    task automatic test_reset();
        int err0;
        err0 = errors;
        checks++;
        if (result_valid_o || illegal_o || result_o !== '0) begin
            $display("Mismatch at %0t: outputs not idle after reset", $time);
            errors++;
        end
        run_instr(enc_r(rv_exec_pkg::F7_BASE, 5'd2, 5'd1, rv_exec_pkg::F3_ADD_SUB, 5'd3));
        check_flags(1'b0, 1'b0);
        report_test("test_reset", err0);
    endtask

    task automatic test_imm_ops();
        int          err0;
        logic [31:0] v;
        logic [31:0] s;
        logic [11:0] imm;
        logic [2:0]  ops [9] = '{rv_exec_pkg::F3_ADD_SUB, rv_exec_pkg::F3_XOR,
                                 rv_exec_pkg::F3_OR, rv_exec_pkg::F3_AND,
                                 rv_exec_pkg::F3_SLT, rv_exec_pkg::F3_SLTU,
                                 rv_exec_pkg::F3_SLL, rv_exec_pkg::F3_SRL_SRA,
                                 rv_exec_pkg::F3_SRL_SRA};
        err0 = errors;
        for (int r = 1; r < 8; r++) begin  // seed x1..x7
            rand_bits(12, v);
            run_instr(enc_i(v[11:0], 5'd0, rv_exec_pkg::F3_ADD_SUB, 5'(r)));
        end
        for (int round = 0; round < 3; round++) begin
            for (int k = 0; k < 9; k++) begin
                rand_bits(12, v);
                rand_bits(6, s);
                if (k >= 6) imm = {(k == 8) ? rv_exec_pkg::F7_ALT : rv_exec_pkg::F7_BASE, v[4:0]};
                else        imm = v[11:0];
                run_instr(enc_i(imm, {2'b00, s[2:0]}, ops[k], {2'b00, s[5:3]}));
            end
        end
        report_test("test_imm_ops", err0);
    endtask

    task automatic test_reg_ops();
        int          err0;
        logic [31:0] v;
        logic [2:0]  ops [10] = '{rv_exec_pkg::F3_ADD_SUB, rv_exec_pkg::F3_ADD_SUB,
                                  rv_exec_pkg::F3_AND, rv_exec_pkg::F3_OR,
                                  rv_exec_pkg::F3_XOR, rv_exec_pkg::F3_SLT,
                                  rv_exec_pkg::F3_SLTU, rv_exec_pkg::F3_SLL,
                                  rv_exec_pkg::F3_SRL_SRA, rv_exec_pkg::F3_SRL_SRA};
        logic [9:0]  alt = 10'b10_0000_0010;  // sub and sra
        err0 = errors;
        for (int r = 8; r < 12; r++) begin
            rand_bits(12, v);
            run_instr(enc_i(v[11:0], 5'd0, rv_exec_pkg::F3_ADD_SUB, 5'(r)));
            run_instr(enc_i(12'd11, 5'(r), rv_exec_pkg::F3_SLL, 5'(r)));
            rand_bits(11, v);
            run_instr(enc_i({1'b0, v[10:0]}, 5'(r), rv_exec_pkg::F3_OR, 5'(r)));
        end
        // each op reads the previous result
        for (int k = 0; k < 10; k++) begin
            run_instr(enc_r(alt[k] ? rv_exec_pkg::F7_ALT : rv_exec_pkg::F7_BASE,
                            5'(9 + k % 3), (k == 0) ? 5'd8 : 5'(11 + k), ops[k], 5'(12 + k)));
        end
        report_test("test_reg_ops", err0);
    endtask

    task automatic test_overflow();
        int err0;
        err0 = errors;
        run_instr(enc_i(12'hfff, 5'd0, rv_exec_pkg::F3_ADD_SUB, 5'd20));
        run_instr(enc_i(12'd1, 5'd20, rv_exec_pkg::F3_SRL_SRA, 5'd20));  // 0x7fffffff
        run_instr(enc_i(12'd1, 5'd0, rv_exec_pkg::F3_ADD_SUB, 5'd21));
        run_instr(enc_r(rv_exec_pkg::F7_BASE, 5'd21, 5'd20, rv_exec_pkg::F3_ADD_SUB, 5'd22));
        check_flags(1'b1, 1'b1);
        run_instr(enc_r(rv_exec_pkg::F7_ALT, 5'd21, 5'd22, rv_exec_pkg::F3_ADD_SUB, 5'd23));
        check_flags(1'b1, 1'b0);
        run_instr(enc_r(rv_exec_pkg::F7_BASE, 5'd21, 5'd22, rv_exec_pkg::F3_AND, 5'd24));
        check_flags(1'b0, 1'b0);
        report_test("test_overflow", err0);
    endtask

    task automatic test_x0_and_illegal();
        int err0;
        err0 = errors;
        run_instr(enc_i(12'd123, 5'd0, rv_exec_pkg::F3_ADD_SUB, 5'd0));
        read_reg(5'd0);
        run_instr({25'h1abcd, 7'b1111111});  // no such major opcode
        check_idle();
        run_instr(enc_r(rv_exec_pkg::F7_ALT, 5'd9, 5'd8, rv_exec_pkg::F3_AND, 5'd8));
        check_idle();
        for (int r = 1; r < 25; r++) begin
            read_reg(5'(r));
        end
        report_test("test_x0_and_illegal", err0);
    endtask

    initial begin
        clk_i         = 1'b0;
        rst_n_i       = 1'b0;
        instr_valid_i = 1'b0;
        instr_i       = '0;
        lfsr          = 32'h4e12e76f;
        errors        = 0;
        checks        = 0;
        for (int r = 0; r < `RV_REG_COUNT; r++) begin
            model[r] = '0;
        end
        repeat (4) @(posedge clk_i);
        #1;
        rst_n_i = 1'b1;
        @(posedge clk_i);
        #1;
        test_reset();
        test_imm_ops();
        test_reg_ops();
        test_overflow();
        test_x0_and_illegal();
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- tb.f
+incdir+include
src/rv_exec_pkg.sv
src/rv_decoder.sv
src/rv_regfile.sv
src/rv_alu.sv
src/rv_exec_top.sv
dv/rv_exec_asserts.sv
dv/rv_exec_tb.sv

//--- Makefile
# Verilator flow for the RV32I execution unit

VERILATOR ?= verilator
TOP       ?= rv_exec_tb
DUT_TOP   ?= rv_exec_top
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --timing --assert
PASS_TEXT ?= All tests passed

SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

$(SIM_BIN): $(FILELIST)
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		-Mdir $(BUILD_DIR) -o V$(TOP)

# pass only if the run prints the pass line
sim: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)
